// ==== dma_pkg.sv ====
// DMA read engine shared definitions
// Bus widths, IDs, register map, commands and FIFO sizing
`default_nettype none

package dma_pkg;

	// FSAB bus
	localparam int FSAB_ADDR_W = 31;
	localparam int FSAB_DATA_W = 64;
	localparam int FSAB_LEN_W = 4;
	localparam int FSAB_DID_W = 4;
	localparam int FSAB_CREDIT_W = 3;

	// SPAM register bus
	localparam int SPAM_ADDR_W = 24;
	localparam int SPAM_DATA_W = 32;
	localparam int SPAM_DID_W = 4;
	localparam int REG_ADDR_W = 8;

	localparam int CMD_W = 2;

	localparam logic [FSAB_DID_W-1:0] DMA_FSAB_DID = 4'd3;
	localparam logic [FSAB_DID_W-1:0] DMA_FSAB_SUBDID = 4'd1;
	localparam logic [SPAM_DID_W-1:0] SPAM_DMA_DID = 4'd2;
	// Block sits in a 256-byte window
	localparam logic [SPAM_ADDR_W-1:0] SPAM_ADDR_PFX = 24'h040000;
	localparam logic [SPAM_ADDR_W-1:0] SPAM_ADDR_MASK = 24'hFFFF00;

	localparam logic [REG_ADDR_W-1:0] REG_NEXT_START = 8'h00;
	localparam logic [REG_ADDR_W-1:0] REG_NEXT_LEN = 8'h04;
	localparam logic [REG_ADDR_W-1:0] REG_COMMAND = 8'h08;
	localparam logic [REG_ADDR_W-1:0] REG_BYTES_READ = 8'h0C;
	localparam logic [REG_ADDR_W-1:0] REG_BYTES_DELIVERED = 8'h10;

	localparam logic [CMD_W-1:0] CMD_STOP = 2'd0;
	localparam logic [CMD_W-1:0] CMD_TRIGGER_ONCE = 2'd1;
	localparam logic [CMD_W-1:0] CMD_AUTOTRIGGER = 2'd2;
	localparam logic FSAB_MODE_READ = 1'b0;

	localparam int BURST_BEATS = 8;
	localparam int BURST_BYTES = 64;
	localparam int BURST_CNT_W = 3;
	localparam int FIFO_DEPTH = 128;
	localparam int FIFO_PTR_W = 7;
	localparam logic [FSAB_CREDIT_W-1:0] FSAB_INITIAL_CREDITS = 3'd4;
	localparam logic [FSAB_ADDR_W-1:0] DEFAULT_START = '0;
	localparam logic [FSAB_ADDR_W-1:0] DEFAULT_LEN = '0;

endpackage

`default_nettype wire

// ==== dma_cfg_if.sv ====
// Configuration and status between the register stage
// and the fetch sequencer
`timescale 1ns/1ps
`default_nettype none

interface dma_cfg_if;
	import dma_pkg::*;

	logic [FSAB_ADDR_W-1:0] start_addr;
	logic [FSAB_ADDR_W-1:0] len;
	logic [CMD_W-1:0]       cmd;
	// Pulses in the cycle the command register is written
	logic                   cmd_wr;
	// Sequencer consumed a trigger-once command
	logic                   cmd_clear;
	logic [FSAB_ADDR_W-1:0] bytes_read;

	modport csr (
		output start_addr, len, cmd, cmd_wr,
		input  cmd_clear, bytes_read
	);

	modport seq (
		input  start_addr, len, cmd, cmd_wr,
		output cmd_clear, bytes_read
	);

endinterface

`default_nettype wire

// ==== dma_burst_if.sv ====
// Burst handshake between the fetch sequencer and the beat buffer
// Issue and done bracket the single outstanding burst
`timescale 1ns/1ps
`default_nettype none

interface dma_burst_if;

	// Read request left this cycle
	logic issue;
	// Last beat of the burst is stored
	logic done;
	// FIFO can take one more full burst
	logic room;

	modport seq (
		output issue,
		input  done, room
	);

	// Beat buffer side
	modport buffer (
		input  issue,
		output done, room
	);

endinterface

`default_nettype wire

// ==== dma_csr_regs.sv ====
// DMA register stage
// Decodes SPAM accesses, holds start, length and command,
// and returns the byte counters with a one-cycle acknowledge
`timescale 1ns/1ps
`default_nettype none

module dma_csr_regs (
	input  logic                             target_clk,
	input  logic                             target_rst_b,
	input  logic                             spamo_valid,
	input  logic                             spamo_r_nw,
	input  logic [dma_pkg::SPAM_DID_W-1:0]   spamo_did,
	input  logic [dma_pkg::SPAM_ADDR_W-1:0]  spamo_addr,
	input  logic [dma_pkg::SPAM_DATA_W-1:0]  spamo_data,
	output logic                             spami_busy_b,
	output logic [dma_pkg::SPAM_DATA_W-1:0]  spami_data,
	input  logic [dma_pkg::FSAB_ADDR_W-1:0]  bytes_delivered,
	dma_cfg_if.csr                           cfg
);
	import dma_pkg::*;

	logic                   sel;
	logic                   wr_sel;
	logic                   rd_sel;
	logic [REG_ADDR_W-1:0]  reg_addr;
	logic                   wr_hit;
	logic                   rd_hit;
	logic [SPAM_DATA_W-1:0] rd_word;

	// Device ID and window match
	assign sel = spamo_valid && (spamo_did == SPAM_DMA_DID) &&
		((spamo_addr & SPAM_ADDR_MASK) == SPAM_ADDR_PFX);
	assign wr_sel = sel && !spamo_r_nw;
	assign rd_sel = sel && spamo_r_nw;
	assign reg_addr = spamo_addr[REG_ADDR_W-1:0];

	assign cfg.cmd_wr = wr_sel && (reg_addr == REG_COMMAND);

	always_comb begin
		wr_hit = 1'b0;
		if (wr_sel) begin
			case (reg_addr)
				REG_NEXT_START, REG_NEXT_LEN, REG_COMMAND: wr_hit = 1'b1;
				default: wr_hit = 1'b0;
			endcase
		end
	end

	// Read mux covers only the counters
	always_comb begin
		rd_hit = 1'b0;
		rd_word = '0;
		if (rd_sel) begin
			case (reg_addr)
				REG_BYTES_READ: begin
					rd_hit = 1'b1;
					rd_word = SPAM_DATA_W'(cfg.bytes_read);
				end
				REG_BYTES_DELIVERED: begin
					rd_hit = 1'b1;
					rd_word = SPAM_DATA_W'(bytes_delivered);
				end
				default: rd_hit = 1'b0;
			endcase
		end
	end

	always_ff @(posedge target_clk or negedge target_rst_b) begin
		if (!target_rst_b) begin
			cfg.start_addr <= DEFAULT_START;
			cfg.len <= DEFAULT_LEN;
			cfg.cmd <= CMD_STOP;
		end else begin
			if (wr_sel && (reg_addr == REG_NEXT_START))
				cfg.start_addr <= spamo_data[FSAB_ADDR_W-1:0];
			if (wr_sel && (reg_addr == REG_NEXT_LEN))
				cfg.len <= spamo_data[FSAB_ADDR_W-1:0];
			// A bus write beats a consumed trigger
			if (cfg.cmd_wr)
				cfg.cmd <= spamo_data[CMD_W-1:0];
			else if (cfg.cmd_clear)
				cfg.cmd <= CMD_STOP;
		end
	end

	// Acknowledge and read data in the cycle after the strobe
	always_ff @(posedge target_clk or negedge target_rst_b) begin
		if (!target_rst_b) begin
			spami_busy_b <= 1'b0;
			spami_data <= '0;
		end else begin
			spami_busy_b <= wr_hit || rd_hit;
			spami_data <= rd_word;
		end
	end

endmodule

`default_nettype wire

// ==== dma_fetch_seq.sv ====
// DMA fetch sequencer
// Tracks the command, walks the block in 64-byte bursts and
// issues FSAB reads under credit and FIFO room
`timescale 1ns/1ps
`default_nettype none

module dma_fetch_seq (
	input  logic                             target_clk,
	input  logic                             target_rst_b,
	output logic                             fsabo_valid,
	output logic                             fsabo_mode,
	output logic [dma_pkg::FSAB_DID_W-1:0]   fsabo_did,
	output logic [dma_pkg::FSAB_DID_W-1:0]   fsabo_subdid,
	output logic [dma_pkg::FSAB_ADDR_W-1:0]  fsabo_addr,
	output logic [dma_pkg::FSAB_LEN_W-1:0]   fsabo_len,
	input  logic                             fsabo_credit,
	dma_cfg_if.seq                           cfg,
	dma_burst_if.seq                         burst
);
	import dma_pkg::*;

	logic                     triggered;
	logic                     pending;
	logic [FSAB_ADDR_W-1:0]   cur_addr;
	logic [FSAB_ADDR_W-1:0]   end_addr;
	logic [FSAB_CREDIT_W-1:0] credits;
	logic [FSAB_ADDR_W-1:0]   next_addr;
	logic                     arm;
	logic                     issue;

	assign next_addr = cur_addr + FSAB_ADDR_W'(BURST_BYTES);
	assign arm = !triggered &&
		((cfg.cmd == CMD_TRIGGER_ONCE) || (cfg.cmd == CMD_AUTOTRIGGER));

	// Trigger-once goes back to stop as it fires
	assign cfg.cmd_clear = !triggered && (cfg.cmd == CMD_TRIGGER_ONCE) && !cfg.cmd_wr;

	assign issue = triggered && !pending && (credits != '0) && burst.room;
	assign burst.issue = issue;

	// Request fields are constant apart from the address
	assign fsabo_valid = issue;
	assign fsabo_mode = FSAB_MODE_READ;
	assign fsabo_did = DMA_FSAB_DID;
	assign fsabo_subdid = DMA_FSAB_SUBDID;
	assign fsabo_addr = cur_addr;
	assign fsabo_len = FSAB_LEN_W'(BURST_BEATS);

	always_ff @(posedge target_clk or negedge target_rst_b) begin
		if (!target_rst_b) begin
			credits <= FSAB_INITIAL_CREDITS;
		end else begin
			case ({fsabo_credit, issue})
				2'b10: credits <= credits + 1'b1;
				2'b01: credits <= credits - 1'b1;
				default: credits <= credits;
			endcase
		end
	end

	always_ff @(posedge target_clk or negedge target_rst_b) begin
		if (!target_rst_b) begin
			triggered <= 1'b0;
			pending <= 1'b0;
			cur_addr <= DEFAULT_START;
			end_addr <= DEFAULT_START + DEFAULT_LEN;
			cfg.bytes_read <= '0;
		end else if (arm) begin
			triggered <= 1'b1;
			cur_addr <= cfg.start_addr;
			end_addr <= cfg.start_addr + cfg.len;
		end else if (issue) begin
			pending <= 1'b1;
		end else if (pending && burst.done) begin
			pending <= 1'b0;
			// Last burst ends the run
			if (next_addr == end_addr) begin
				triggered <= 1'b0;
				cfg.bytes_read <= '0;
			end else begin
				cur_addr <= next_addr;
				cfg.bytes_read <= cfg.bytes_read + FSAB_ADDR_W'(BURST_BYTES);
			end
		end
	end

endmodule

`default_nettype wire

// ==== dma_beat_fifo.sv ====
// DMA beat buffer
// Accepts response beats for this engine, stores them in a FIFO
// and hands one beat out per user pull
`timescale 1ns/1ps
`default_nettype none

module dma_beat_fifo (
	input  logic                             target_clk,
	input  logic                             target_rst_b,
	input  logic                             fsabi_valid,
	input  logic [dma_pkg::FSAB_DID_W-1:0]   fsabi_did,
	input  logic [dma_pkg::FSAB_DID_W-1:0]   fsabi_subdid,
	input  logic [dma_pkg::FSAB_DATA_W-1:0]  fsabi_data,
	input  logic                             request,
	output logic [dma_pkg::FSAB_DATA_W-1:0]  data,
	output logic                             data_ready,
	output logic                             fifo_empty,
	output logic [dma_pkg::FSAB_ADDR_W-1:0]  bytes_delivered,
	dma_burst_if.buffer                      burst
);
	import dma_pkg::*;

	logic [FSAB_DATA_W-1:0] mem [FIFO_DEPTH];
	logic [FIFO_PTR_W-1:0]  wr_ptr;
	logic [FIFO_PTR_W-1:0]  rd_ptr;
	logic [FIFO_PTR_W:0]    count;
	logic [BURST_CNT_W-1:0] beat_cnt;
	logic                   hit;
	logic                   pop;

	// Only beats addressed to this engine
	assign hit = fsabi_valid && (fsabi_did == DMA_FSAB_DID) &&
		(fsabi_subdid == DMA_FSAB_SUBDID);
	assign pop = request && !fifo_empty;

	assign fifo_empty = (count == '0);
	// Keep space for a whole burst before asking for one
	assign burst.room = (int'(count) + BURST_BEATS) <= FIFO_DEPTH;

	always_ff @(posedge target_clk) begin
		if (hit)
			mem[wr_ptr] <= fsabi_data;
	end

	always_ff @(posedge target_clk) begin
		if (pop)
			data <= mem[rd_ptr];
	end

	always_ff @(posedge target_clk or negedge target_rst_b) begin
		if (!target_rst_b) begin
			wr_ptr <= '0;
			beat_cnt <= '0;
			burst.done <= 1'b0;
		end else begin
			if (hit)
				wr_ptr <= wr_ptr + 1'b1;
			// New burst restarts the beat count
			if (burst.issue)
				beat_cnt <= '0;
			else if (hit)
				beat_cnt <= beat_cnt + 1'b1;
			burst.done <= hit && (beat_cnt == BURST_CNT_W'(BURST_BEATS - 1));
		end
	end

	always_ff @(posedge target_clk or negedge target_rst_b) begin
		if (!target_rst_b) begin
			rd_ptr <= '0;
			data_ready <= 1'b0;
			bytes_delivered <= '0;
		end else begin
			data_ready <= pop;
			if (pop) begin
				rd_ptr <= rd_ptr + 1'b1;
				bytes_delivered <= bytes_delivered + FSAB_ADDR_W'(FSAB_DATA_W / 8);
			end
		end
	end

	// Occupancy
	always_ff @(posedge target_clk or negedge target_rst_b) begin
		if (!target_rst_b) begin
			count <= '0;
		end else begin
			case ({hit, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== dma_read_top.sv ====
// Read DMA engine top level
// Register stage, fetch sequencer and beat buffer on one clock
`timescale 1ns/1ps
`default_nettype none

module dma_read_top (
	input  logic                             target_clk,
	input  logic                             target_rst_b,
	// FSAB request
	output logic                             fsabo_valid,
	output logic                             fsabo_mode,
	output logic [dma_pkg::FSAB_DID_W-1:0]   fsabo_did,
	output logic [dma_pkg::FSAB_DID_W-1:0]   fsabo_subdid,
	output logic [dma_pkg::FSAB_ADDR_W-1:0]  fsabo_addr,
	output logic [dma_pkg::FSAB_LEN_W-1:0]   fsabo_len,
	input  logic                             fsabo_credit,
	// FSAB response
	input  logic                             fsabi_valid,
	input  logic [dma_pkg::FSAB_DID_W-1:0]   fsabi_did,
	input  logic [dma_pkg::FSAB_DID_W-1:0]   fsabi_subdid,
	input  logic [dma_pkg::FSAB_DATA_W-1:0]  fsabi_data,
	// SPAM
	input  logic                             spamo_valid,
	input  logic                             spamo_r_nw,
	input  logic [dma_pkg::SPAM_DID_W-1:0]   spamo_did,
	input  logic [dma_pkg::SPAM_ADDR_W-1:0]  spamo_addr,
	input  logic [dma_pkg::SPAM_DATA_W-1:0]  spamo_data,
	output logic                             spami_busy_b,
	output logic [dma_pkg::SPAM_DATA_W-1:0]  spami_data,
	// User pull port
	input  logic                             request,
	output logic [dma_pkg::FSAB_DATA_W-1:0]  data,
	output logic                             data_ready,
	output logic                             fifo_empty
);
	import dma_pkg::*;

	logic [FSAB_ADDR_W-1:0] bytes_delivered;

	dma_cfg_if cfg_if ();
	dma_burst_if burst_if ();

	dma_csr_regs u_csr (
		.target_clk      (target_clk),
		.target_rst_b    (target_rst_b),
		.spamo_valid     (spamo_valid),
		.spamo_r_nw      (spamo_r_nw),
		.spamo_did       (spamo_did),
		.spamo_addr      (spamo_addr),
		.spamo_data      (spamo_data),
		.spami_busy_b    (spami_busy_b),
		.spami_data      (spami_data),
		.bytes_delivered (bytes_delivered),
		.cfg             (cfg_if.csr)
	);

	dma_fetch_seq u_seq (
		.target_clk   (target_clk),
		.target_rst_b (target_rst_b),
		.fsabo_valid  (fsabo_valid),
		.fsabo_mode   (fsabo_mode),
		.fsabo_did    (fsabo_did),
		.fsabo_subdid (fsabo_subdid),
		.fsabo_addr   (fsabo_addr),
		.fsabo_len    (fsabo_len),
		.fsabo_credit (fsabo_credit),
		.cfg          (cfg_if.seq),
		.burst        (burst_if.seq)
	);

	dma_beat_fifo u_fifo (
		.target_clk      (target_clk),
		.target_rst_b    (target_rst_b),
		.fsabi_valid     (fsabi_valid),
		.fsabi_did       (fsabi_did),
		.fsabi_subdid    (fsabi_subdid),
		.fsabi_data      (fsabi_data),
		.request         (request),
		.data            (data),
		.data_ready      (data_ready),
		.fifo_empty      (fifo_empty),
		.bytes_delivered (bytes_delivered),
		.burst           (burst_if.buffer)
	);

endmodule

`default_nettype wire

// ==== tb_clkgen.sv ====
// Testbench clock and reset source
// 10 ns clock, reset held low for the first 16 cycles
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen (
	output logic target_clk,
	output logic target_rst_b
);
	localparam int RESET_CYCLES = 16;

	initial begin
		target_clk = 1'b0;
		forever #5 target_clk = ~target_clk;
	end

	initial begin
		target_rst_b = 1'b0;
		repeat (RESET_CYCLES) @(posedge target_clk);
		target_rst_b <= 1'b1;
	end

endmodule

`default_nettype wire

// ==== tb_dma_read.sv ====
// Testbench for the read DMA engine
// FSAB responder, SPAM driver, user puller and stream checker around the DUT
`timescale 1ns/1ps
`default_nettype none

module tb_dma_read;
	import dma_pkg::*;

	localparam int BEAT_BYTES = FSAB_DATA_W / 8;
	localparam int FULL_BURSTS = FIFO_DEPTH / BURST_BEATS;
	// About 60 bursts at under 40 cycles each plus register traffic and margin
	localparam int TIMEOUT_CYCLES = 20000;

	logic                   target_clk;
	logic                   target_rst_b;
	logic                   fsabo_valid;
	logic                   fsabo_mode;
	logic [FSAB_DID_W-1:0]  fsabo_did;
	logic [FSAB_DID_W-1:0]  fsabo_subdid;
	logic [FSAB_ADDR_W-1:0] fsabo_addr;
	logic [FSAB_LEN_W-1:0]  fsabo_len;
	logic                   fsabo_credit;
	logic                   fsabi_valid;
	logic [FSAB_DID_W-1:0]  fsabi_did;
	logic [FSAB_DID_W-1:0]  fsabi_subdid;
	logic [FSAB_DATA_W-1:0] fsabi_data;
	logic                   spamo_valid;
	logic                   spamo_r_nw;
	logic [SPAM_DID_W-1:0]  spamo_did;
	logic [SPAM_ADDR_W-1:0] spamo_addr;
	logic [SPAM_DATA_W-1:0] spamo_data;
	logic                   spami_busy_b;
	logic [SPAM_DATA_W-1:0] spami_data;
	logic                   request;
	logic [FSAB_DATA_W-1:0] data;
	logic                   data_ready;
	logic                   fifo_empty;

	// Expected request addresses and beats, plus requests waiting for the responder
	logic [FSAB_ADDR_W-1:0] exp_reqs[$];
	logic [FSAB_DATA_W-1:0] exp_beats[$];
	logic [FSAB_ADDR_W-1:0] req_q[$];
	int cycles = 0;
	int beats_seen = 0;
	int reqs_seen = 0;
	int runs_queued = 0;
	int foreign_sent = 0;
	int credit_model = int'(FSAB_INITIAL_CREDITS);
	int credits_owed = 0;
	int base_reqs = 0;
	int base_beats = 0;
	int base_runs = 0;
	int run_len = 0;
	logic [FSAB_ADDR_W-1:0] run_start = '0;
	logic pull_en = 1'b0;
	logic foreign_on = 1'b0;
	logic auto_mode = 1'b0;
	logic resp_busy = 1'b0;
	logic credit_hold = 1'b0;

	tb_clkgen u_clkgen (
		.target_clk   (target_clk),
		.target_rst_b (target_rst_b)
	);

	dma_read_top DUT (
		.target_clk   (target_clk),
		.target_rst_b (target_rst_b),
		.fsabo_valid  (fsabo_valid),
		.fsabo_mode   (fsabo_mode),
		.fsabo_did    (fsabo_did),
		.fsabo_subdid (fsabo_subdid),
		.fsabo_addr   (fsabo_addr),
		.fsabo_len    (fsabo_len),
		.fsabo_credit (fsabo_credit),
		.fsabi_valid  (fsabi_valid),
		.fsabi_did    (fsabi_did),
		.fsabi_subdid (fsabi_subdid),
		.fsabi_data   (fsabi_data),
		.spamo_valid  (spamo_valid),
		.spamo_r_nw   (spamo_r_nw),
		.spamo_did    (spamo_did),
		.spamo_addr   (spamo_addr),
		.spamo_data   (spamo_data),
		.spami_busy_b (spami_busy_b),
		.spami_data   (spami_data),
		.request      (request),
		.data         (data),
		.data_ready   (data_ready),
		.fifo_empty   (fifo_empty)
	);

	task automatic report_failure(input string msg);
		$display("%s", msg);
		$display("Result: FAILED");
		$fatal(1, "simulation stopped on error");
	endtask

	task automatic check_beat(input string name, input logic [FSAB_DATA_W-1:0] got,
		input logic [FSAB_DATA_W-1:0] exp);
		if (got !== exp)
			report_failure($sformatf("mismatch %s: got %h expected %h", name, got, exp));
	endtask

	task automatic check_addr(input string name, input logic [FSAB_ADDR_W-1:0] got,
		input logic [FSAB_ADDR_W-1:0] exp);
		if (got !== exp)
			report_failure($sformatf("mismatch %s: got %h expected %h", name, got, exp));
	endtask

	task automatic check_reg(input string name, input logic [SPAM_DATA_W-1:0] got,
		input logic [SPAM_DATA_W-1:0] exp);
		if (got !== exp)
			report_failure($sformatf("mismatch %s: got %h expected %h", name, got, exp));
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp)
			report_failure($sformatf("mismatch %s: got %h expected %h", name, got, exp));
	endtask

	// Memory model with the address in the low word and its inverse in the high word
	function automatic logic [FSAB_DATA_W-1:0] beat_at(input logic [FSAB_ADDR_W-1:0] addr);
		logic [31:0] word;
		word = 32'(addr);
		return {~word, word};
	endfunction

	function automatic void queue_run(input logic [FSAB_ADDR_W-1:0] start, input int len);
		for (int b = 0; b < len / BURST_BYTES; b++)
			exp_reqs.push_back(start + FSAB_ADDR_W'(b * BURST_BYTES));
		for (int k = 0; k < len / BEAT_BYTES; k++)
			exp_beats.push_back(beat_at(start + FSAB_ADDR_W'(k * BEAT_BYTES)));
		runs_queued++;
	endfunction

	// Beat stream, request and credit monitor
	always @(posedge target_clk) begin
		cycles++;
		if (cycles >= TIMEOUT_CYCLES) begin
			report_failure("timeout: the test sequence did not finish within the cycle limit");
		end else if (target_rst_b) begin
			if (data_ready) begin
				if (exp_beats.size() == 0)
					report_failure("a beat was delivered when none was expected");
				else
					check_beat("data", data, exp_beats.pop_front());
				beats_seen++;
			end
			if (fsabo_valid) begin
				if (credit_model == 0)
					report_failure("a request was issued with no credit left");
				else if (exp_reqs.size() == 0 && !auto_mode)
					report_failure("a request was issued past the end of the block");
				else begin
					// Auto-trigger restarts the block
					if (exp_reqs.size() == 0)
						queue_run(run_start, run_len);
					check_addr("fsabo_addr", fsabo_addr, exp_reqs.pop_front());
					check_bit("fsabo_mode", fsabo_mode, FSAB_MODE_READ);
					check_reg("fsabo_len", 32'(fsabo_len), 32'(BURST_BEATS));
					check_reg("fsabo_did", 32'(fsabo_did), 32'(DMA_FSAB_DID));
					check_reg("fsabo_subdid", 32'(fsabo_subdid), 32'(DMA_FSAB_SUBDID));
					reqs_seen++;
					req_q.push_back(fsabo_addr);
				end
				if (reqs_seen * BURST_BEATS - beats_seen > FIFO_DEPTH)
					report_failure("requested beats exceed the FIFO depth");
			end
			credit_model = credit_model + int'(fsabo_credit) - int'(fsabo_valid);
		end
	end

	task automatic serve_burst(input logic [FSAB_ADDR_W-1:0] base);
		int beat;
		int unsigned pick;
		beat = 0;
		while (beat < BURST_BEATS) begin
			@(posedge target_clk);
			pick = $urandom_range(0, 7);
			if (foreign_on && pick == 0) begin
				fsabi_valid <= 1'b1;
				fsabi_data <= {$urandom, $urandom};
				if ($urandom_range(0, 1) == 0) begin
					fsabi_did <= DMA_FSAB_DID + 4'd1;
					fsabi_subdid <= DMA_FSAB_SUBDID;
				end else begin
					fsabi_did <= DMA_FSAB_DID;
					fsabi_subdid <= DMA_FSAB_SUBDID + 4'd1;
				end
				foreign_sent++;
			end else if (pick == 1) begin
				fsabi_valid <= 1'b0;
			end else begin
				fsabi_valid <= 1'b1;
				fsabi_did <= DMA_FSAB_DID;
				fsabi_subdid <= DMA_FSAB_SUBDID;
				fsabi_data <= beat_at(base + FSAB_ADDR_W'(beat * BEAT_BYTES));
				beat++;
			end
		end
		@(posedge target_clk);
		fsabi_valid <= 1'b0;
		// Credit goes back through the return process
		@(negedge target_clk);
		credits_owed++;
	endtask

	// FSAB responder
	initial begin : responder
		logic [FSAB_ADDR_W-1:0] addr;
		int unsigned delay;
		fsabi_valid = 1'b0;
		fsabi_did = '0;
		fsabi_subdid = '0;
		fsabi_data = '0;
		forever begin
			@(negedge target_clk);
			if (req_q.size() != 0) begin
				addr = req_q.pop_front();
				resp_busy = 1'b1;
				delay = $urandom_range(1, 6);
				repeat (delay) @(posedge target_clk);
				serve_burst(addr);
				resp_busy = 1'b0;
			end
		end
	end

	// One credit pulse per cycle while credits are owed and not held back
	initial begin : credit_return
		fsabo_credit = 1'b0;
		forever begin
			@(posedge target_clk);
			if (!credit_hold && credits_owed != 0) begin
				fsabo_credit <= 1'b1;
				credits_owed--;
			end else begin
				fsabo_credit <= 1'b0;
			end
		end
	end

	// User side pulls with random gaps
	initial begin : puller
		request = 1'b0;
		forever begin
			@(posedge target_clk);
			request <= pull_en && ($urandom_range(0, 3) != 0);
		end
	end

	task automatic spam_access(input logic r_nw, input logic [SPAM_DID_W-1:0] did,
		input logic [REG_ADDR_W-1:0] reg_addr, input logic [SPAM_DATA_W-1:0] wdata,
		input logic ack_exp, input logic [SPAM_DATA_W-1:0] rdata_exp);
		@(posedge target_clk);
		spamo_valid <= 1'b1;
		spamo_r_nw <= r_nw;
		spamo_did <= did;
		spamo_addr <= SPAM_ADDR_PFX | SPAM_ADDR_W'(reg_addr);
		spamo_data <= wdata;
		@(posedge target_clk);
		spamo_valid <= 1'b0;
		check_bit("spami_busy_b", spami_busy_b, 1'b0);
		@(posedge target_clk);
		check_bit("spami_busy_b", spami_busy_b, ack_exp);
		if (r_nw && ack_exp)
			check_reg("spami_data", spami_data, rdata_exp);
		@(posedge target_clk);
		check_bit("spami_busy_b", spami_busy_b, 1'b0);
		check_reg("spami_data", spami_data, '0);
	endtask

	task automatic write_reg(input logic [REG_ADDR_W-1:0] reg_addr,
		input logic [SPAM_DATA_W-1:0] value);
		spam_access(1'b0, SPAM_DMA_DID, reg_addr, value, 1'b1, '0);
	endtask

	task automatic read_reg(input logic [REG_ADDR_W-1:0] reg_addr,
		input logic [SPAM_DATA_W-1:0] exp);
		spam_access(1'b1, SPAM_DMA_DID, reg_addr, '0, 1'b1, exp);
	endtask

	task automatic trigger_once(input logic [FSAB_ADDR_W-1:0] start, input int len);
		queue_run(start, len);
		write_reg(REG_NEXT_START, 32'(start));
		write_reg(REG_NEXT_LEN, 32'(len));
		write_reg(REG_COMMAND, 32'(CMD_TRIGGER_ONCE));
	endtask

	// Everything expected has been requested, served and pulled
	task automatic wait_idle();
		@(negedge target_clk);
		while (exp_beats.size() != 0 || exp_reqs.size() != 0 || req_q.size() != 0 ||
			resp_busy || credits_owed != 0 || !fifo_empty || data_ready)
			@(negedge target_clk);
	endtask

	initial begin : main_seq
		void'($urandom(32'hb63b));
		spamo_valid = 1'b0;
		spamo_r_nw = 1'b0;
		spamo_did = '0;
		spamo_addr = '0;
		spamo_data = '0;

		// Reset state during and after reset
		repeat (4) @(negedge target_clk);
		check_bit("fsabo_valid", fsabo_valid, 1'b0);
		check_bit("data_ready", data_ready, 1'b0);
		check_bit("fifo_empty", fifo_empty, 1'b1);
		check_bit("spami_busy_b", spami_busy_b, 1'b0);
		wait (target_rst_b === 1'b1);
		@(negedge target_clk);
		check_bit("fsabo_valid", fsabo_valid, 1'b0);
		check_bit("fifo_empty", fifo_empty, 1'b1);

		// Single trigger-once run
		pull_en = 1'b1;
		base_reqs = reqs_seen;
		base_beats = beats_seen;
		trigger_once(31'h1000, 512);
		wait_idle();
		repeat (40) @(negedge target_clk);
		check_reg("request count", 32'(reqs_seen - base_reqs), 32'd8);
		check_reg("beat count", 32'(beats_seen - base_beats), 32'd64);

		// Register read-back and ignored accesses
		read_reg(REG_BYTES_DELIVERED, 32'(beats_seen * BEAT_BYTES));
		read_reg(REG_BYTES_READ, '0);
		spam_access(1'b1, SPAM_DMA_DID + 4'd1, REG_BYTES_DELIVERED, '0, 1'b0, '0);
		spam_access(1'b1, SPAM_DMA_DID, REG_NEXT_START, '0, 1'b0, '0);
		spam_access(1'b0, SPAM_DMA_DID, 8'h20, 32'h5, 1'b0, '0);

		// Beats for other devices mixed into the bursts
		@(negedge target_clk);
		foreign_on = 1'b1;
		trigger_once(31'h2000, 512);
		wait_idle();
		foreign_on = 1'b0;
		if (foreign_sent == 0)
			report_failure("no foreign beats were injected");

		// FIFO fills with no pulls and then drains
		pull_en = 1'b0;
		base_reqs = reqs_seen;
		// Credits held back first so the engine runs dry
		credit_hold = 1'b1;
		trigger_once(31'h8000, 2048);
		@(negedge target_clk);
		while (!(reqs_seen == base_reqs + int'(FSAB_INITIAL_CREDITS) && !resp_busy &&
			req_q.size() == 0))
			@(negedge target_clk);
		repeat (40) @(negedge target_clk);
		check_reg("requests without credit", 32'(reqs_seen - base_reqs),
			32'(FSAB_INITIAL_CREDITS));
		credit_hold = 1'b0;
		while (!(reqs_seen == base_reqs + FULL_BURSTS && !resp_busy && req_q.size() == 0))
			@(negedge target_clk);
		repeat (40) @(negedge target_clk);
		check_reg("requests while full", 32'(reqs_seen - base_reqs), 32'(FULL_BURSTS));
		check_bit("fifo_empty", fifo_empty, 1'b0);
		read_reg(REG_BYTES_READ, 32'(FULL_BURSTS * BURST_BYTES));
		pull_en = 1'b1;
		wait_idle();
		check_reg("request count", 32'(reqs_seen - base_reqs), 32'(2 * FULL_BURSTS));

		// Auto-trigger until stopped
		run_start = 31'h3000;
		run_len = 192;
		auto_mode = 1'b1;
		base_runs = runs_queued;
		write_reg(REG_NEXT_START, 32'(run_start));
		write_reg(REG_NEXT_LEN, 32'(run_len));
		write_reg(REG_COMMAND, 32'(CMD_AUTOTRIGGER));
		@(negedge target_clk);
		while (runs_queued < base_runs + 3)
			@(negedge target_clk);
		write_reg(REG_COMMAND, 32'(CMD_STOP));
		wait_idle();
		repeat (40) @(negedge target_clk);
		if (exp_beats.size() != 0 || exp_reqs.size() != 0)
			report_failure("a new auto-trigger run started after the stop command");
		auto_mode = 1'b0;
		read_reg(REG_BYTES_READ, '0);
		read_reg(REG_BYTES_DELIVERED, 32'(beats_seen * BEAT_BYTES));

		$display("Result: PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== flist.f ====
dma_pkg.sv
dma_cfg_if.sv
dma_burst_if.sv
dma_csr_regs.sv
dma_fetch_seq.sv
dma_beat_fifo.sv
dma_read_top.sv
tb_clkgen.sv
tb_dma_read.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the read DMA testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_dma_read -f flist.f -o tb_dma_read_sim
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit $status
fi

./obj_dir/tb_dma_read_sim
status=$?
if [ $status -ne 0 ]; then
	echo "Simulation failed with status $status"
	exit $status
fi

exit 0
